//--- Bender.yml
package:
  name: dcache

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dcache_pkg.sv
      - hw/dcache_way.sv
      - hw/dcache_read_select.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_top.sv
      - target: test
        files:
          - test/dcache_assert.sv
          - test/dcache_tb.sv

//--- hw/dcache_ctrl.sv
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cmd_e        c_cmd,
    input  addr_t       c_address,
    input  load_type_e  c_load_type,
    input  store_type_e c_store_type,
    input  word_t       c_store_data,
    input  logic        hit,
    input  way_idx_t    hit_way,
    input  logic        mem_rvalid,
    input  word_t       mem_rdata,
    output response_e   c_response,
    output logic        mem_read,
    output logic        mem_write,
    output addr_t       mem_addr,
    output word_t       mem_wdata,
    output byte_mask_t  mem_wstrb,
    output logic        rd_en,
    output lane_t       rd_lane,
    output offset_t     rd_offset,
    output tag_t        cmp_tag,
    output way_mask_t   data_we,
    output way_mask_t   tag_we,
    output lane_t       wr_lane,
    output offset_t     wr_offset,
    output byte_mask_t  wr_mask,
    output word_t       wr_data,
    output logic        invalidate_all,
    output inword_t     inword,
    output load_type_e  load_type
);

    state_e   state;
    logic     os_active;
    offset_t  refill_cnt;
    way_idx_t victim;

    // Output stage payload
    cmd_e        os_cmd;
    tag_t        os_tag;
    lane_t       os_lane;
    offset_t     os_offset;
    inword_t     os_inword;
    load_type_e  os_load_type;
    store_type_e os_store_type;
    word_t       os_store_data;

    tag_t    c_tag;
    lane_t   c_lane;
    offset_t c_offset;

    logic       capture;
    logic       respond;
    logic       unknown_type;
    logic       misaligned;
    logic       req_ok;
    logic       store_go;
    logic       load_miss;
    logic       last_beat;
    byte_mask_t st_mask;
    word_t      st_data;

    assign c_offset = c_address[`DCACHE_OFFSET_W+1:2];
    assign c_lane   = c_address[`DCACHE_LANES_W+`DCACHE_OFFSET_W+1:`DCACHE_OFFSET_W+2];
    assign c_tag    = c_address[31:`DCACHE_LANES_W+`DCACHE_OFFSET_W+2];

    // Only loads and stores occupy the output stage
    assign capture = (state == ACTIVE) && !os_active && (c_cmd == LOAD || c_cmd == STORE);
    assign respond = (state == ACTIVE) && os_active;

    always_ff @(posedge clk) begin
        if (capture) begin
            os_cmd        <= c_cmd;
            os_tag        <= c_tag;
            os_lane       <= c_lane;
            os_offset     <= c_offset;
            os_inword     <= c_address[1:0];
            os_load_type  <= c_load_type;
            os_store_type <= c_store_type;
            os_store_data <= c_store_data;
        end
    end

    // Unknown type wins over misalignment
    always_comb begin
        if (os_cmd == LOAD) begin
            unknown_type = !(os_load_type inside {LB, LBU, LH, LHU, LW});
            case (os_load_type)
                LH, LHU: misaligned = os_inword[0];
                LW:      misaligned = |os_inword;
                default: misaligned = 1'b0;
            endcase
        end else begin
            unknown_type = !(os_store_type inside {SB, SH, SW});
            case (os_store_type)
                SH:      misaligned = os_inword[0];
                SW:      misaligned = |os_inword;
                default: misaligned = 1'b0;
            endcase
        end
    end

    assign req_ok    = respond && !unknown_type && !misaligned;
    assign store_go  = req_ok && (os_cmd == STORE);
    assign load_miss = req_ok && (os_cmd == LOAD) && !hit;
    assign last_beat = mem_rvalid && (refill_cnt == offset_t'(`DCACHE_WORDS - 1));

    // Store lanes and data placed at the byte offset
    always_comb begin
        case (os_store_type)
            SB: begin
                st_mask = 4'b0001 << os_inword;
                st_data = {24'b0, os_store_data[7:0]} << {os_inword, 3'b000};
            end
            SH: begin
                st_mask = 4'b0011 << os_inword;
                st_data = {16'b0, os_store_data[15:0]} << {os_inword, 3'b000};
            end
            default: begin
                st_mask = 4'b1111;
                st_data = os_store_data;
            end
        endcase
    end

    always_comb begin
        c_response = IDLE;
        if (state == FLUSH) begin
            c_response = DONE;
        end else if (respond) begin
            if (unknown_type) begin
                c_response = UNKNOWNTYPE;
            end else if (misaligned) begin
                c_response = MISALIGNED;
            end else if (os_cmd == STORE || hit) begin
                c_response = DONE;
            end
        end
    end

    assign mem_read  = load_miss;
    assign mem_write = store_go;
    assign mem_addr  = {os_tag, os_lane, store_go ? os_offset : offset_t'(0), 2'b00};
    assign mem_wdata = st_data;
    assign mem_wstrb = st_mask;

    // Lookup comes from the core, or from the stage during replay
    assign rd_en     = capture || (state == REPLAY);
    assign rd_lane   = (state == REPLAY) ? os_lane : c_lane;
    assign rd_offset = (state == REPLAY) ? os_offset : c_offset;
    assign cmp_tag   = os_tag;

    assign wr_lane   = os_lane;
    assign wr_offset = (state == REFILL) ? refill_cnt : os_offset;
    assign wr_mask   = (state == REFILL) ? 4'b1111 : st_mask;
    assign wr_data   = (state == REFILL) ? mem_rdata : st_data;

    always_comb begin
        data_we = '0;
        tag_we  = '0;
        if (state == REFILL && mem_rvalid) begin
            data_we[victim] = 1'b1;
            tag_we[victim]  = last_beat;
        end else if (store_go && hit) begin
            // Write through, update only on hit
            data_we[hit_way] = 1'b1;
        end
    end

    assign invalidate_all = (state == FLUSH);
    assign inword         = os_inword;
    assign load_type      = os_load_type;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ACTIVE;
            os_active  <= 1'b0;
            refill_cnt <= '0;
            victim     <= '0;
        end else begin
            case (state)
                ACTIVE: begin
                    if (load_miss) begin
                        state      <= REFILL;
                        refill_cnt <= '0;
                    end else if (respond) begin
                        os_active <= 1'b0;
                    end else if (capture) begin
                        os_active <= 1'b1;
                    end else if (c_cmd == FLUSH_ALL) begin
                        state <= FLUSH;
                    end
                end
                REFILL: begin
                    if (mem_rvalid) begin
                        refill_cnt <= refill_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state  <= REPLAY;
                        victim <= way_idx_t'(victim + 1'b1);
                    end
                end
                // Stage stays active so ACTIVE answers from the new line
                REPLAY: state <= ACTIVE;
                default: state <= ACTIVE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Number of ways in each set
`define DCACHE_WAYS 2

// Set index width, 16 sets
`define DCACHE_LANES_W 4

// Word-in-line index width
`define DCACHE_OFFSET_W 4

// Words per line, must equal 2**DCACHE_OFFSET_W
`define DCACHE_WORDS 16

`endif

//--- hw/dcache_pkg.sv
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Address split: tag | lane | offset | inword
    typedef logic [31-`DCACHE_LANES_W-`DCACHE_OFFSET_W-2:0] tag_t;
    typedef logic [`DCACHE_LANES_W-1:0] lane_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;
    typedef logic [1:0] inword_t;

    typedef logic [3:0] byte_mask_t;
    typedef logic [`DCACHE_WAYS-1:0] way_mask_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_idx_t;

    typedef enum logic [1:0] {
        NONE      = 2'd0,
        LOAD      = 2'd1,
        STORE     = 2'd2,
        FLUSH_ALL = 2'd3
    } cmd_e;

    // Encoded like the RISC-V funct3 field
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_type_e;

    typedef enum logic [1:0] {
        SB = 2'b00,
        SH = 2'b01,
        SW = 2'b10
    } store_type_e;

    typedef enum logic [1:0] {
        IDLE        = 2'd0,
        DONE        = 2'd1,
        MISALIGNED  = 2'd2,
        UNKNOWNTYPE = 2'd3
    } response_e;

    typedef enum logic [1:0] {
        ACTIVE,
        REFILL,
        REPLAY,
        FLUSH
    } state_e;

endpackage

`default_nettype wire

//--- hw/dcache_read_select.sv
`default_nettype none

`include "dcache_params.svh"

module dcache_read_select
    import dcache_pkg::*;
(
    input  way_mask_t  way_hit,
    input  word_t      way_rdata [`DCACHE_WAYS],
    input  inword_t    inword,
    input  load_type_e load_type,
    output logic       hit,
    output way_idx_t   hit_way,
    output word_t      load_data
);

    word_t sel_word;
    word_t shifted;

    // At most one way hits, the loop just finds which
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        sel_word = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit      = 1'b1;
                hit_way  = way_idx_t'(w);
                sel_word = way_rdata[w];
            end
        end
    end

    // Move the addressed byte or halfword down to bit 0
    assign shifted = sel_word >> {inword, 3'b000};

    always_comb begin
        case (load_type)
            LB: begin
                load_data = {{24{shifted[7]}}, shifted[7:0]};
            end
            LBU: begin
                load_data = {24'b0, shifted[7:0]};
            end
            LH: begin
                load_data = {{16{shifted[15]}}, shifted[15:0]};
            end
            LHU: begin
                load_data = {16'b0, shifted[15:0]};
            end
            default: begin
                // LW, and unknown types which never reach DONE
                load_data = sel_word;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/dcache_top.sv
`default_nettype none

`include "dcache_params.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cmd_e        c_cmd,
    input  addr_t       c_address,
    input  load_type_e  c_load_type,
    input  store_type_e c_store_type,
    input  word_t       c_store_data,
    output response_e   c_response,
    output word_t       c_load_data,
    output logic        mem_read,
    output logic        mem_write,
    output addr_t       mem_addr,
    output word_t       mem_wdata,
    output byte_mask_t  mem_wstrb,
    input  logic        mem_rvalid,
    input  word_t       mem_rdata
);

    logic       rd_en;
    lane_t      rd_lane;
    offset_t    rd_offset;
    tag_t       cmp_tag;
    way_mask_t  data_we;
    way_mask_t  tag_we;
    lane_t      wr_lane;
    offset_t    wr_offset;
    byte_mask_t wr_mask;
    word_t      wr_data;
    logic       invalidate_all;
    inword_t    inword;
    load_type_e load_type;
    logic       hit;
    way_idx_t   hit_way;
    way_mask_t  way_hit;
    word_t      way_rdata [`DCACHE_WAYS];

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .c_cmd          (c_cmd),
        .c_address      (c_address),
        .c_load_type    (c_load_type),
        .c_store_type   (c_store_type),
        .c_store_data   (c_store_data),
        .hit            (hit),
        .hit_way        (hit_way),
        .mem_rvalid     (mem_rvalid),
        .mem_rdata      (mem_rdata),
        .c_response     (c_response),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_wstrb      (mem_wstrb),
        .rd_en          (rd_en),
        .rd_lane        (rd_lane),
        .rd_offset      (rd_offset),
        .cmp_tag        (cmp_tag),
        .data_we        (data_we),
        .tag_we         (tag_we),
        .wr_lane        (wr_lane),
        .wr_offset      (wr_offset),
        .wr_mask        (wr_mask),
        .wr_data        (wr_data),
        .invalidate_all (invalidate_all),
        .inword         (inword),
        .load_type      (load_type)
    );

    // One storage block per way, write enables split per way
    for (genvar g = 0; g < `DCACHE_WAYS; g++) begin : g_way
        dcache_way u_way (
            .clk            (clk),
            .rst_n          (rst_n),
            .rd_en          (rd_en),
            .rd_lane        (rd_lane),
            .rd_offset      (rd_offset),
            .cmp_tag        (cmp_tag),
            .data_we        (data_we[g]),
            .tag_we         (tag_we[g]),
            .wr_lane        (wr_lane),
            .wr_offset      (wr_offset),
            .wr_mask        (wr_mask),
            .wr_data        (wr_data),
            .invalidate_all (invalidate_all),
            .way_hit        (way_hit[g]),
            .way_rdata      (way_rdata[g])
        );
    end

    dcache_read_select u_read_select (
        .way_hit   (way_hit),
        .way_rdata (way_rdata),
        .inword    (inword),
        .load_type (load_type),
        .hit       (hit),
        .hit_way   (hit_way),
        .load_data (c_load_data)
    );

endmodule

`default_nettype wire

//--- hw/dcache_way.sv
`default_nettype none

`include "dcache_params.svh"

module dcache_way
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rd_en,
    input  lane_t      rd_lane,
    input  offset_t    rd_offset,
    input  tag_t       cmp_tag,
    input  logic       data_we,
    input  logic       tag_we,
    input  lane_t      wr_lane,
    input  offset_t    wr_offset,
    input  byte_mask_t wr_mask,
    input  word_t      wr_data,
    input  logic       invalidate_all,
    output logic       way_hit,
    output word_t      way_rdata
);

    localparam int SETS = 1 << `DCACHE_LANES_W;

    tag_t            tag_mem  [SETS];
    word_t           data_mem [SETS * `DCACHE_WORDS];
    logic [SETS-1:0] valid;

    tag_t tag_q;
    logic valid_q;

    // Valid bits, cleared as a whole on flush
    always_ff @(posedge clk) begin
        if (!rst_n || invalidate_all) begin
            valid <= '0;
        end else if (tag_we) begin
            valid[wr_lane] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[wr_lane] <= cmp_tag;
        end
    end

    // Byte-enabled line storage
    always_ff @(posedge clk) begin
        if (data_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b]) begin
                    data_mem[{wr_lane, wr_offset}][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // Synchronous lookup read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            tag_q     <= tag_mem[rd_lane];
            way_rdata <= data_mem[{rd_lane, rd_offset}];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (rd_en) begin
            valid_q <= valid[rd_lane];
        end
    end

    assign way_hit = valid_q && (tag_q == cmp_tag);

endmodule

`default_nettype wire

//--- test/dcache_assert.sv
`default_nettype none

module dcache_assert
    import dcache_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      mem_read,
    input logic      mem_write,
    input response_e c_response
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed protocol assertions
    int unsigned fail_count = 0;

    // One memory strobe per cycle at most
    a_read_write_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_read && mem_write)
    ) else begin
        $error("mem_read and mem_write are high in the same cycle");
        fail_count++;
    end

    // Write-through goes out only with a completed store
    a_write_done: assert property (
        @(posedge clk) disable iff (!rst_n) mem_write |-> (c_response == DONE)
    ) else begin
        $error("mem_write without a DONE response");
        fail_count++;
    end

    a_single_response: assert property (
        @(posedge clk) disable iff (!rst_n) (c_response != IDLE) |=> (c_response == IDLE)
    ) else begin
        $error("c_response is not IDLE in two consecutive cycles");
        fail_count++;
    end

endmodule

bind dcache_ctrl dcache_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .c_response (c_response)
);

`default_nettype wire

//--- test/dcache_tb.sv
`default_nettype none

`include "dcache_params.svh"

module dcache_tb
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_AW       = 12;
    localparam int SETS         = 1 << `DCACHE_LANES_W;
    localparam int RESP_TIMEOUT = 400;

    typedef struct packed {
        cmd_e       cmd;
        addr_t      addr;
        logic [2:0] typ;
        word_t      data;
        response_e  resp;
        logic       refill;
    } row_t;

    logic        clk          = 1'b0;
    logic        rst_n        = 1'b0;
    cmd_e        c_cmd        = NONE;
    addr_t       c_address    = '0;
    load_type_e  c_load_type  = LW;
    store_type_e c_store_type = SW;
    word_t       c_store_data = '0;
    logic        mem_rvalid   = 1'b0;
    word_t       mem_rdata    = '0;
    response_e   c_response;
    word_t       c_load_data;
    logic        mem_read;
    logic        mem_write;
    addr_t       mem_addr;
    word_t       mem_wdata;
    byte_mask_t  mem_wstrb;

    word_t             mem     [1 << MEM_AW];
    word_t             ref_mem [1 << MEM_AW];
    logic [15:0]       lfsr        = 16'd48106;
    int                read_count  = 0;
    int                write_count = 0;
    logic              burst_on    = 1'b0;
    int                beat        = 0;
    logic [MEM_AW-1:0] line_base;

    row_t rows [$];
    tag_t sh_tag   [`DCACHE_WAYS][SETS];
    logic sh_valid [`DCACHE_WAYS][SETS];
    int   sh_victim  = 0;
    int   mismatches = 0;
    int   fails      = 0;

    always #20 clk = ~clk;

    dcache_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .c_load_type  (c_load_type),
        .c_store_type (c_store_type),
        .c_store_data (c_store_data),
        .c_response   (c_response),
        .c_load_data  (c_load_data),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_wstrb    (mem_wstrb),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata)
    );

    // Taps x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t load_expect(word_t w, logic [1:0] off, load_type_e lt);
        word_t s;
        s = w >> (8 * off);
        case (lt)
            LB:      return {{24{s[7]}}, s[7:0]};
            LBU:     return {24'b0, s[7:0]};
            LH:      return {{16{s[15]}}, s[15:0]};
            LHU:     return {16'b0, s[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic invalidate_shadow();
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                sh_valid[w][s] = 1'b0;
            end
        end
    endtask

    task automatic add_row(input cmd_e cmd, input addr_t addr, input int typ,
                           input word_t data, input response_e resp, input bit refill);
        row_t r;
        r = '{cmd, addr, 3'(typ), data, resp, refill};
        rows.push_back(r);
    endtask

    task automatic build_table();
        // cmd, address, type, store data, response, refill
        add_row(LOAD,  32'h0000_0040, LW,  0, DONE, 1);
        add_row(LOAD,  32'h0000_0044, LW,  0, DONE, 0);
        add_row(LOAD,  32'h0000_0081, LB,  0, DONE, 1);
        add_row(LOAD,  32'h0000_0080, LB,  0, DONE, 0);
        add_row(LOAD,  32'h0000_0083, LB,  0, DONE, 0);
        add_row(LOAD,  32'h0000_0082, LB,  0, DONE, 0);
        add_row(LOAD,  32'h0000_00C2, LBU, 0, DONE, 1);
        add_row(LOAD,  32'h0000_00C1, LBU, 0, DONE, 0);
        add_row(LOAD,  32'h0000_00C7, LBU, 0, DONE, 0);
        add_row(LOAD,  32'h0000_00C0, LBU, 0, DONE, 0);
        add_row(LOAD,  32'h0000_0102, LH,  0, DONE, 1);
        add_row(LOAD,  32'h0000_0104, LH,  0, DONE, 0);
        add_row(LOAD,  32'h0000_0142, LHU, 0, DONE, 1);
        add_row(LOAD,  32'h0000_0148, LHU, 0, DONE, 0);
        // Store hits merge into the cached line
        add_row(STORE, 32'h0000_0048, SW,  32'hDEAD_BEEF, DONE, 0);
        add_row(STORE, 32'h0000_0049, SB,  32'h0000_00A5, DONE, 0);
        add_row(STORE, 32'h0000_004A, SH,  32'h0000_8E71, DONE, 0);
        add_row(LOAD,  32'h0000_0048, LW,  0, DONE, 0);
        add_row(LOAD,  32'h0000_004B, LB,  0, DONE, 0);
        // Store miss does not allocate
        add_row(STORE, 32'h0000_0187, SB,  32'h0000_007E, DONE, 0);
        add_row(LOAD,  32'h0000_0184, LW,  0, DONE, 1);
        // Three tags in set 7
        add_row(LOAD,  32'h0000_01C0, LW,  0, DONE, 1);
        add_row(LOAD,  32'h0000_05C4, LW,  0, DONE, 1);
        add_row(LOAD,  32'h0000_09C8, LW,  0, DONE, 1);
        add_row(LOAD,  32'h0000_05C0, LW,  0, DONE, 0);
        add_row(LOAD,  32'h0000_01CC, LW,  0, DONE, 1);
        add_row(FLUSH_ALL, 32'h0, 0, 0, DONE, 0);
        add_row(LOAD,  32'h0000_0044, LW,  0, DONE, 1);
        // Errors leave memory and arrays alone
        add_row(LOAD,  32'h0000_0042, LW,  0, MISALIGNED, 0);
        add_row(LOAD,  32'h0000_0041, LH,  0, MISALIGNED, 0);
        add_row(LOAD,  32'h0000_0043, LHU, 0, MISALIGNED, 0);
        add_row(STORE, 32'h0000_0046, SW,  32'h1111_2222, MISALIGNED, 0);
        add_row(STORE, 32'h0000_0045, SH,  32'h0000_3333, MISALIGNED, 0);
        add_row(LOAD,  32'h0000_0040, 3,   0, UNKNOWNTYPE, 0);
        add_row(LOAD,  32'h0000_0043, 7,   0, UNKNOWNTYPE, 0);
        add_row(STORE, 32'h0000_0041, 3,   32'h4444_5555, UNKNOWNTYPE, 0);
        add_row(LOAD,  32'h0000_0040, LW,  0, DONE, 0);
    endtask

    // Memory model that applies write strobes and streams a line after each read strobe
    always @(negedge clk) begin
        mem_rvalid = 1'b0;
        if (mem_write) begin
            write_count++;
            for (int b = 0; b < 4; b++) begin
                if (mem_wstrb[b]) begin
                    mem[mem_addr[MEM_AW+1:2]][8*b +: 8] = mem_wdata[8*b +: 8];
                end
            end
        end
        if (mem_read) begin
            read_count++;
            assert (mem_addr[`DCACHE_OFFSET_W+1:0] == '0) else begin
                fails++;
                $display("Refill address %08h is not line aligned", mem_addr);
            end
            line_base = mem_addr[MEM_AW+1:2];
            beat      = 0;
            burst_on  = 1'b1;
        end else if (burst_on && take_bits(1) != 0) begin
            mem_rvalid = 1'b1;
            mem_rdata  = mem[int'(line_base) + beat];
            beat++;
            if (beat == `DCACHE_WORDS) begin
                burst_on = 1'b0;
            end
        end
    end

    initial begin
        row_t       r;
        int         cycles;
        int         reads0;
        int         writes0;
        int         widx;
        lane_t      ln;
        tag_t       tg;
        logic       miss;
        logic       store_ok;
        logic [1:0] off;
        word_t      exp_data;
        byte_mask_t exp_strb;
        word_t      exp_wdata;

        for (int i = 0; i < (1 << MEM_AW); i++) begin
            mem[i]     = take_bits(32);
            ref_mem[i] = mem[i];
        end
        invalidate_shadow();
        build_table();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        foreach (rows[i]) begin
            r        = rows[i];
            off      = r.addr[1:0];
            widx     = int'(r.addr[MEM_AW+1:2]);
            ln       = lane_t'(r.addr >> (`DCACHE_OFFSET_W + 2));
            tg       = tag_t'(r.addr >> (`DCACHE_LANES_W + `DCACHE_OFFSET_W + 2));
            store_ok = (r.cmd == STORE) && (r.resp == DONE);

            // Shadow tags and victim pointer predict the refill
            miss = 1'b0;
            if (r.cmd == FLUSH_ALL) begin
                invalidate_shadow();
            end else if (r.cmd == LOAD && r.resp == DONE) begin
                miss = 1'b1;
                for (int w = 0; w < `DCACHE_WAYS; w++) begin
                    if (sh_valid[w][ln] && sh_tag[w][ln] == tg) begin
                        miss = 1'b0;
                    end
                end
                if (miss) begin
                    sh_tag[sh_victim][ln]   = tg;
                    sh_valid[sh_victim][ln] = 1'b1;
                    sh_victim = (sh_victim + 1) % `DCACHE_WAYS;
                end
            end
            assert (miss == r.refill) else begin
                fails++;
                $display("Row %0d: refill flag in the table disagrees with the tag model", i);
            end

            reads0       = read_count;
            writes0      = write_count;
            c_cmd        = r.cmd;
            c_address    = r.addr;
            c_load_type  = load_type_e'(r.typ);
            c_store_type = store_type_e'(r.typ[1:0]);
            c_store_data = r.data;
            @(negedge clk);
            c_cmd  = NONE;
            cycles = 0;
            while (c_response == IDLE && cycles < RESP_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            assert (c_response != IDLE) else begin
                fails++;
                $display("Row %0d: no response within %0d cycles", i, RESP_TIMEOUT);
            end
            if (c_response == IDLE) begin
                break;
            end

            // Everything except a refill answers in the cycle after capture
            assert (miss || cycles == 0) else begin
                fails++;
                $display("Row %0d: response came %0d cycles later than expected", i, cycles);
            end

            assert (c_response == r.resp) else begin
                mismatches++;
                $display("MISMATCH row %0d c_response: expected %0h, got %0h",
                         i, r.resp, c_response);
            end
            if (r.cmd == LOAD && r.resp == DONE) begin
                exp_data = load_expect(ref_mem[widx], off, load_type_e'(r.typ));
                assert (c_load_data == exp_data) else begin
                    mismatches++;
                    $display("MISMATCH row %0d c_load_data: expected %08h, got %08h",
                             i, exp_data, c_load_data);
                end
            end
            if (store_ok) begin
                case (r.typ[1:0])
                    SB: begin
                        exp_strb  = 4'b0001 << off;
                        exp_wdata = {24'b0, r.data[7:0]} << (8 * off);
                    end
                    SH: begin
                        exp_strb  = 4'b0011 << off;
                        exp_wdata = {16'b0, r.data[15:0]} << (8 * off);
                    end
                    default: begin
                        exp_strb  = 4'b1111;
                        exp_wdata = r.data;
                    end
                endcase
                assert (mem_wstrb == exp_strb) else begin
                    mismatches++;
                    $display("MISMATCH row %0d mem_wstrb: expected %0h, got %0h",
                             i, exp_strb, mem_wstrb);
                end
                assert (mem_wdata == exp_wdata) else begin
                    mismatches++;
                    $display("MISMATCH row %0d mem_wdata: expected %08h, got %08h",
                             i, exp_wdata, mem_wdata);
                end
                assert (mem_addr == {r.addr[31:2], 2'b00}) else begin
                    mismatches++;
                    $display("MISMATCH row %0d mem_addr: expected %08h, got %08h",
                             i, {r.addr[31:2], 2'b00}, mem_addr);
                end
                for (int b = 0; b < 4; b++) begin
                    if (exp_strb[b]) begin
                        ref_mem[widx][8*b +: 8] = exp_wdata[8*b +: 8];
                    end
                end
            end

            // Strobe counters settle at the next falling edge
            @(negedge clk);
            assert (read_count - reads0 == int'(miss)) else begin
                mismatches++;
                $display("MISMATCH row %0d mem_read count: expected %0h, got %0h",
                         i, int'(miss), read_count - reads0);
            end
            assert (write_count - writes0 == int'(store_ok)) else begin
                mismatches++;
                $display("MISMATCH row %0d mem_write count: expected %0h, got %0h",
                         i, int'(store_ok), write_count - writes0);
            end
        end

        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, fails, u_dut.u_ctrl.u_assert.fail_count);
        if (mismatches == 0 && fails == 0 && u_dut.u_ctrl.u_assert.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_way.sv
hw/dcache_read_select.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
test/dcache_assert.sv
test/dcache_tb.sv
